/* Bender.yml */
package:
  name: hub_linear

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/hubLinearPkg.sv
      - hdl/hubApbRegs.sv
      - hdl/hubStreamGen.sv
      - hdl/hubAccumulator.sv
      - hdl/hubActivation.sv
      - hdl/hubLinearTop.sv

  - target: simulation
    include_dirs:
      - hdl
      - testbench
    files:
      - testbench/tb_hubLinear.sv

/* build.f */
+incdir+hdl
+incdir+testbench
hdl/hubLinearPkg.sv
hdl/hubApbRegs.sv
hdl/hubStreamGen.sv
hdl/hubAccumulator.sv
hdl/hubActivation.sv
hdl/hubLinearTop.sv
testbench/tb_hubLinear.sv

/* hdl/hubAccumulator.sv */
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module hubAccumulator (
    input  logic                    clk,
    input  logic                    arstN,
    input  hubLinearPkg::streamBeat beat,
    output hubLinearPkg::accResult  acc
);

    localparam int CNTW  = $clog2(`HUB_IDIM) + 1;
    localparam int NPAIR = `HUB_IDIM / 2;
    localparam logic [`HUB_ACCWID-1:0] ACCMAX = `HUB_IDIM * `HUB_PERIOD;

    logic [`HUB_ODIM-1:0][NPAIR-1:0][1:0]     pairSum;
    logic [`HUB_ODIM-1:0][CNTW-1:0]           treeSum;
    logic [`HUB_ODIM-1:0][CNTW-1:0]           cnt;
    logic                                     cntValid;
    logic                                     cntLast;
    logic                                     cntFirst;
    logic                                     expectFirst;
    logic [`HUB_ODIM-1:0][`HUB_ACCWID-1:0]    accReg;
    logic                                     accValid;

    // two-level adder tree per output
    always_comb begin
        for (int o = 0; o < `HUB_ODIM; o++) begin
            treeSum[o] = '0;
            for (int p = 0; p < NPAIR; p++) begin
                pairSum[o][p] = {1'b0, beat.prod[o * `HUB_IDIM + 2 * p]}
                              + {1'b0, beat.prod[o * `HUB_IDIM + 2 * p + 1]};
                treeSum[o] = treeSum[o] + CNTW'(pairSum[o][p]);
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cnt         <= '0;
            cntValid    <= 1'b0;
            cntLast     <= 1'b0;
            cntFirst    <= 1'b0;
            expectFirst <= 1'b1;
        end else begin
            cntValid <= beat.valid;
            cntLast  <= beat.valid && beat.last;
            cntFirst <= beat.valid && expectFirst;
            if (beat.valid) begin
                cnt         <= treeSum;
                expectFirst <= beat.last;
            end
        end
    end

    // first count of a run restarts the sum
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            accReg   <= '0;
            accValid <= 1'b0;
        end else begin
            accValid <= cntValid && cntLast;
            if (cntValid) begin
                for (int o = 0; o < `HUB_ODIM; o++) begin
                    accReg[o] <= (cntFirst ? '0 : accReg[o]) + `HUB_ACCWID'(cnt[o]);
                end
            end
        end
    end

    assign acc.total = accReg;
    assign acc.valid = accValid;

    for (genvar o = 0; o < `HUB_ODIM; o++) begin : genAccBound
        accInRange: assert property (@(posedge clk) disable iff (!arstN)
            accReg[o] <= ACCMAX);
    end

endmodule

/* hdl/hubActivation.sv */
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module hubActivation (
    input  logic                               clk,
    input  logic                               arstN,
    input  hubLinearPkg::accResult             acc,
    input  logic                               reluEn,
    output logic [`HUB_ODIM-1:0][`HUB_WID-1:0] results,
    output logic                               resValid
);

    localparam int RSH = $clog2(`HUB_IDIM);
    // total that maps to a bipolar zero
    localparam logic [`HUB_ACCWID-1:0] HALF   = `HUB_IDIM * `HUB_PERIOD / 2;
    localparam logic [`HUB_ACCWID-1:0] SATMAX = (1 << `HUB_WID) - 1;

    logic [`HUB_ODIM-1:0][`HUB_ACCWID-1:0] scaled;
    logic [`HUB_ODIM-1:0][`HUB_WID-1:0]    resNext;

    always_comb begin
        for (int o = 0; o < `HUB_ODIM; o++) begin
            if (reluEn) begin
                scaled[o] = (acc.total[o] > HALF) ? (acc.total[o] - HALF) >> RSH : '0;
            end else begin
                scaled[o] = acc.total[o] >> (RSH + 1);
            end
            resNext[o] = (scaled[o] > SATMAX) ? SATMAX[`HUB_WID-1:0] : scaled[o][`HUB_WID-1:0];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            results  <= '0;
            resValid <= 1'b0;
        end else begin
            resValid <= acc.valid;
            if (acc.valid) begin
                results <= resNext;
            end
        end
    end

endmodule

/* hdl/hubApbRegs.sv */
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module hubApbRegs (
    input  logic                                          clk,
    input  logic                                          arstN,
    input  hubLinearPkg::apbReq                           apbIn,
    input  logic                                          resValid,
    input  logic [`HUB_ODIM-1:0][`HUB_WID-1:0]            results,
    output hubLinearPkg::apbRsp                           apbOut,
    output logic                                          runGo,
    output logic [`HUB_IDIM-1:0][`HUB_WID-1:0]            features,
    output logic [`HUB_ODIM*`HUB_IDIM-1:0][`HUB_WID-1:0]  weights,
    output logic                                          reluEn
);

    localparam int FIDXW = $clog2(`HUB_IDIM);
    localparam int WIDXW = $clog2(`HUB_ODIM * `HUB_IDIM);
    localparam int RIDXW = $clog2(`HUB_ODIM);

    hubLinearPkg::runState             state;
    logic [`HUB_WID-1:0]               streamCnt;
    logic [`HUB_ODIM-1:0][`HUB_WID-1:0] resReg;
    logic                              busy;
    logic                              done;
    logic                              access;
    logic                              hitCtrl;
    logic                              hitStatus;
    logic                              hitFeat;
    logic                              hitWeig;
    logic                              hitRes;
    logic                              mapped;
    logic                              readOnly;
    logic                              locked;
    logic                              wrAcc;
    logic                              startOk;
    logic [FIDXW-1:0]                  featIdx;
    logic [WIDXW-1:0]                  weigIdx;
    logic [RIDXW-1:0]                  resIdx;

    assign busy   = (state == hubLinearPkg::STREAM) || (state == hubLinearPkg::DRAIN);
    assign done   = state == hubLinearPkg::DONE;
    assign access = apbIn.psel && apbIn.penable;

    // word index within each register group
    assign featIdx = apbIn.paddr[2 +: FIDXW];
    assign weigIdx = apbIn.paddr[2 +: WIDXW];
    assign resIdx  = apbIn.paddr[2 +: RIDXW];

    always_comb begin
        hitCtrl   = 1'b0;
        hitStatus = 1'b0;
        hitFeat   = 1'b0;
        hitWeig   = 1'b0;
        hitRes    = 1'b0;
        case (apbIn.paddr)
            hubLinearPkg::CTRL:   hitCtrl = 1'b1;
            hubLinearPkg::STATUS: hitStatus = 1'b1;
            hubLinearPkg::FEAT0, hubLinearPkg::FEAT1,
            hubLinearPkg::FEAT2, hubLinearPkg::FEAT3: hitFeat = 1'b1;
            hubLinearPkg::WEIG0, hubLinearPkg::WEIG1,
            hubLinearPkg::WEIG2, hubLinearPkg::WEIG3,
            hubLinearPkg::WEIG4, hubLinearPkg::WEIG5,
            hubLinearPkg::WEIG6, hubLinearPkg::WEIG7: hitWeig = 1'b1;
            hubLinearPkg::RES0, hubLinearPkg::RES1: hitRes = 1'b1;
            default: ;
        endcase
    end

    assign mapped   = hitCtrl || hitStatus || hitFeat || hitWeig || hitRes;
    assign readOnly = hitStatus || hitRes;
    // operands frozen while a run is in flight
    assign locked   = busy && (hitCtrl || hitFeat || hitWeig);
    assign wrAcc    = access && apbIn.pwrite && mapped && !readOnly && !locked;
    assign startOk  = wrAcc && hitCtrl && apbIn.pwdata[0];

    always_comb begin
        apbOut.prdata  = '0;
        apbOut.pready  = 1'b1;
        apbOut.pslverr = access && (!mapped || (apbIn.pwrite && (readOnly || locked)));
        if (hitCtrl) begin
            apbOut.prdata[1] = reluEn;
        end else if (hitStatus) begin
            apbOut.prdata[1:0] = {done, busy};
        end else if (hitFeat) begin
            apbOut.prdata[`HUB_WID-1:0] = features[featIdx];
        end else if (hitWeig) begin
            apbOut.prdata[`HUB_WID-1:0] = weights[weigIdx];
        end else if (hitRes) begin
            apbOut.prdata[`HUB_WID-1:0] = resReg[resIdx];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            features <= '0;
            weights  <= '0;
            reluEn   <= 1'b0;
            resReg   <= '0;
        end else begin
            if (wrAcc && hitFeat) begin
                features[featIdx] <= apbIn.pwdata[`HUB_WID-1:0];
            end
            if (wrAcc && hitWeig) begin
                weights[weigIdx] <= apbIn.pwdata[`HUB_WID-1:0];
            end
            if (wrAcc && hitCtrl) begin
                reluEn <= apbIn.pwdata[1];
            end
            if (resValid) begin
                resReg <= results;
            end
        end
    end

    // STREAM lasts one period and DRAIN waits for the results
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= hubLinearPkg::IDLE;
            streamCnt <= '0;
            runGo     <= 1'b0;
        end else begin
            runGo <= startOk;
            case (state)
                hubLinearPkg::IDLE, hubLinearPkg::DONE: begin
                    if (startOk) begin
                        state     <= hubLinearPkg::STREAM;
                        streamCnt <= '0;
                    end
                end
                hubLinearPkg::STREAM: begin
                    streamCnt <= streamCnt + 1'b1;
                    if (streamCnt == `HUB_WID'(`HUB_PERIOD - 1)) begin
                        state <= hubLinearPkg::DRAIN;
                    end
                end
                hubLinearPkg::DRAIN: begin
                    if (resValid) begin
                        state <= hubLinearPkg::DONE;
                    end
                end
                default: state <= hubLinearPkg::IDLE;
            endcase
        end
    end

    // pipeline latency outlasts the stream period
    resultsInDrain: assert property (@(posedge clk) disable iff (!arstN)
        resValid |-> state == hubLinearPkg::DRAIN);

    operandsHeld: assert property (@(posedge clk) disable iff (!arstN)
        busy && access && apbIn.pwrite |=> $stable(features) && $stable(weights));

endmodule

/* hdl/hubLinearPkg.sv */
`include "hubLinear_cfg.svh"

package hubLinearPkg;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [`HUB_AWID-1:0]  paddr;
        logic [31:0]           pwdata;
    } apbReq;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp;

    // one product bit per output/input pair, index o*IDIM+i
    typedef struct packed {
        logic [`HUB_ODIM*`HUB_IDIM-1:0] prod;
        logic                           valid;
        logic                           last;
    } streamBeat;

    typedef struct packed {
        logic [`HUB_ODIM-1:0][`HUB_ACCWID-1:0] total;
        logic                                  valid;
    } accResult;

    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        DRAIN,
        DONE
    } runState;

    typedef enum logic [`HUB_AWID-1:0] {
        CTRL   = 8'h00,
        STATUS = 8'h04,
        FEAT0  = 8'h10,
        FEAT1  = 8'h14,
        FEAT2  = 8'h18,
        FEAT3  = 8'h1C,
        WEIG0  = 8'h20,
        WEIG1  = 8'h24,
        WEIG2  = 8'h28,
        WEIG3  = 8'h2C,
        WEIG4  = 8'h30,
        WEIG5  = 8'h34,
        WEIG6  = 8'h38,
        WEIG7  = 8'h3C,
        RES0   = 8'h40,
        RES1   = 8'h44
    } regAddr;

endpackage

/* hdl/hubLinearTop.sv */
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module hubLinearTop (
    input  logic                clk,
    input  logic                arstN,
    input  hubLinearPkg::apbReq apbIn,
    output hubLinearPkg::apbRsp apbOut
);

    logic                                          runGo;
    logic                                          reluEn;
    logic                                          resValid;
    logic [`HUB_IDIM-1:0][`HUB_WID-1:0]            features;
    logic [`HUB_ODIM*`HUB_IDIM-1:0][`HUB_WID-1:0]  weights;
    logic [`HUB_ODIM-1:0][`HUB_WID-1:0]            results;
    hubLinearPkg::streamBeat                       beat;
    hubLinearPkg::accResult                        acc;

    hubApbRegs uApbRegs (
        .clk      (clk),
        .arstN    (arstN),
        .apbIn    (apbIn),
        .resValid (resValid),
        .results  (results),
        .apbOut   (apbOut),
        .runGo    (runGo),
        .features (features),
        .weights  (weights),
        .reluEn   (reluEn)
    );

    // producer
    hubStreamGen uStreamGen (
        .clk      (clk),
        .arstN    (arstN),
        .runGo    (runGo),
        .features (features),
        .weights  (weights),
        .beat     (beat)
    );

    // buffer
    hubAccumulator uAccumulator (
        .clk   (clk),
        .arstN (arstN),
        .beat  (beat),
        .acc   (acc)
    );

    // consumer
    hubActivation uActivation (
        .clk      (clk),
        .arstN    (arstN),
        .acc      (acc),
        .reluEn   (reluEn),
        .results  (results),
        .resValid (resValid)
    );

endmodule

/* hdl/hubLinear_cfg.svh */
`ifndef HUB_LINEAR_CFG_SVH
`define HUB_LINEAR_CFG_SVH

// layer shape
`define HUB_IDIM 4
`define HUB_ODIM 2

// data and sequence width
`define HUB_WID 6

// one full stream period
`define HUB_PERIOD (1 << `HUB_WID)

// popcount width plus data width
`define HUB_ACCWID ($clog2(`HUB_IDIM) + 1 + `HUB_WID)

// host bus
`define HUB_AWID 8

`endif

/* hdl/hubStreamGen.sv */
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module hubStreamGen (
    input  logic                                          clk,
    input  logic                                          arstN,
    input  logic                                          runGo,
    input  logic [`HUB_IDIM-1:0][`HUB_WID-1:0]            features,
    input  logic [`HUB_ODIM*`HUB_IDIM-1:0][`HUB_WID-1:0]  weights,
    output hubLinearPkg::streamBeat                       beat
);

    logic [`HUB_WID-1:0]               k;
    logic [`HUB_WID-1:0]               kRev;
    logic                              running;
    logic                              active;
    logic [`HUB_IDIM-1:0]              inBit;
    logic [`HUB_ODIM*`HUB_IDIM-1:0]    weigBit;
    logic [`HUB_ODIM*`HUB_IDIM-1:0]    prodBit;

    // bit-reversed counter is the 1-D low-discrepancy sequence
    always_comb begin
        for (int b = 0; b < `HUB_WID; b++) begin
            kRev[b] = k[`HUB_WID-1-b];
        end
    end

    always_comb begin
        for (int i = 0; i < `HUB_IDIM; i++) begin
            inBit[i] = features[i] > kRev;
        end
        for (int w = 0; w < `HUB_ODIM * `HUB_IDIM; w++) begin
            weigBit[w] = weights[w] > k;
            // bipolar multiply
            prodBit[w] = ~(weigBit[w] ^ inBit[w % `HUB_IDIM]);
        end
    end

    assign active = runGo || running;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            k       <= '0;
            running <= 1'b0;
            beat    <= '0;
        end else begin
            beat.valid <= active;
            beat.last  <= active && (k == '1);
            if (active) begin
                beat.prod <= prodBit;
                k         <= k + 1'b1;
                // counter wraps to zero after the final beat
                running   <= (k != '1);
            end
        end
    end

    oneLastPerRun: assert property (@(posedge clk) disable iff (!arstN)
        runGo |=> (!beat.last)[*(`HUB_PERIOD - 1)] ##1 beat.last);

endmodule

/* testbench/tbApbTasks.svh */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// both tasks start and end 1 ns after a rising edge
// setup phase, then access phase, then bus back to idle

task automatic apbWrite(
    input  logic [`HUB_AWID-1:0] addr,
    input  logic [31:0]          data,
    output logic                 err
);
    apbIn.psel    = 1'b1;
    apbIn.penable = 1'b0;
    apbIn.pwrite  = 1'b1;
    apbIn.paddr   = addr;
    apbIn.pwdata  = data;
    @(posedge clk);
    #1;
    apbIn.penable = 1'b1;
    // response is stable mid access phase
    @(negedge clk);
    err = apbOut.pslverr;
    if (apbOut.pready !== 1'b1) begin
        $display("error at %0t: pready was low in a write access phase", $time);
        errCount++;
    end
    @(posedge clk);
    #1;
    apbIn.psel    = 1'b0;
    apbIn.penable = 1'b0;
    apbIn.pwrite  = 1'b0;
endtask

task automatic apbRead(
    input  logic [`HUB_AWID-1:0] addr,
    output logic [31:0]          data,
    output logic                 err
);
    apbIn.psel    = 1'b1;
    apbIn.penable = 1'b0;
    apbIn.pwrite  = 1'b0;
    apbIn.paddr   = addr;
    apbIn.pwdata  = '0;
    @(posedge clk);
    #1;
    apbIn.penable = 1'b1;
    @(negedge clk);
    data = apbOut.prdata;
    err  = apbOut.pslverr;
    if (apbOut.pready !== 1'b1) begin
        $display("error at %0t: pready was low in a read access phase", $time);
        errCount++;
    end
    @(posedge clk);
    #1;
    apbIn.psel    = 1'b0;
    apbIn.penable = 1'b0;
endtask

`endif

/* testbench/tb_hubLinear.sv */
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module tb_hubLinear;

    localparam int NRUNS  = 20;
    localparam int MAXCYC = NRUNS * (`HUB_PERIOD + 40);

    typedef struct packed {
        logic [7:0]          outIdx;
        logic [`HUB_WID-1:0] expVal;
        logic [`HUB_WID-1:0] gotVal;
    } resCheck;

    logic                                         clk = 1'b0;
    logic                                         arstN;
    hubLinearPkg::apbReq                          apbIn;
    hubLinearPkg::apbRsp                          apbOut;

    logic [`HUB_IDIM-1:0][`HUB_WID-1:0]           featV;
    logic [`HUB_ODIM*`HUB_IDIM-1:0][`HUB_WID-1:0] weigV;
    resCheck                                      checkQ[$];
    int                                           errCount = 0;
    int                                           testErrBase = 0;
    int                                           passCount = 0;
    int                                           failCount = 0;
    int                                           cycles = 0;

    hubLinearTop dut_i (
        .clk    (clk),
        .arstN  (arstN),
        .apbIn  (apbIn),
        .apbOut (apbOut)
    );

    `include "tbApbTasks.svh"

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAXCYC) begin
            $display("timeout: no result after %0d clock cycles", MAXCYC);
            $display("TB FAILED");
            $finish;
        end
    end

    // expected 6-bit result for output o, straight from the stream rules
    function automatic int expectedResult(
        input logic [`HUB_IDIM-1:0][`HUB_WID-1:0]           feat,
        input logic [`HUB_ODIM*`HUB_IDIM-1:0][`HUB_WID-1:0] weig,
        input int                                           o,
        input bit                                           relu
    );
        int total;
        int rev;
        int half;
        int val;
        bit xBit;
        bit wBit;
        total = 0;
        half  = `HUB_IDIM * `HUB_PERIOD / 2;
        for (int k = 0; k < `HUB_PERIOD; k++) begin
            rev = 0;
            for (int b = 0; b < `HUB_WID; b++) begin
                rev = rev | (((k >> b) & 1) << (`HUB_WID - 1 - b));
            end
            for (int i = 0; i < `HUB_IDIM; i++) begin
                xBit = feat[i] > rev;
                wBit = weig[o * `HUB_IDIM + i] > k;
                // xnor of the two streams
                if (xBit == wBit) begin
                    total++;
                end
            end
        end
        if (relu) begin
            val = (total > half) ? (total - half) / `HUB_IDIM : 0;
        end else begin
            val = total / (2 * `HUB_IDIM);
        end
        if (val > (1 << `HUB_WID) - 1) begin
            val = (1 << `HUB_WID) - 1;
        end
        return val;
    endfunction

    function automatic logic [`HUB_AWID-1:0] wordAddr(
        input logic [`HUB_AWID-1:0] base,
        input int                   idx
    );
        return base + `HUB_AWID'(4 * idx);
    endfunction

    // result comparison
    always begin
        wait (checkQ.size() != 0);
        if (checkQ[0].gotVal !== checkQ[0].expVal) begin
            $display("MISMATCH at %0t: RES%0d read %0d, expected %0d", $time,
                     checkQ[0].outIdx, checkQ[0].gotVal, checkQ[0].expVal);
            errCount++;
        end
        void'(checkQ.pop_front());
    end

    task automatic openTest();
        testErrBase = errCount;
    endtask

    task automatic closeTest(input string name);
        if (errCount == testErrBase) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, errCount - testErrBase);
        end
    endtask

    task automatic randomOperands();
        for (int i = 0; i < `HUB_IDIM; i++) begin
            featV[i] = `HUB_WID'($urandom_range(0, `HUB_PERIOD - 1));
        end
        for (int w = 0; w < `HUB_ODIM * `HUB_IDIM; w++) begin
            weigV[w] = `HUB_WID'($urandom_range(0, `HUB_PERIOD - 1));
        end
    endtask

    task automatic loadOperands();
        logic err;
        for (int i = 0; i < `HUB_IDIM; i++) begin
            apbWrite(wordAddr(hubLinearPkg::FEAT0, i), 32'(featV[i]), err);
            if (err) begin
                $display("error at %0t: feature write %0d was refused", $time, i);
                errCount++;
            end
        end
        for (int w = 0; w < `HUB_ODIM * `HUB_IDIM; w++) begin
            apbWrite(wordAddr(hubLinearPkg::WEIG0, w), 32'(weigV[w]), err);
            if (err) begin
                $display("error at %0t: weight write %0d was refused", $time, w);
                errCount++;
            end
        end
    endtask

    task automatic startRun(input bit relu);
        logic err;
        apbWrite(hubLinearPkg::CTRL, {30'd0, relu, 1'b1}, err);
        if (err) begin
            $display("error at %0t: start write was refused", $time);
            errCount++;
        end
    endtask

    task automatic waitDone();
        logic [31:0] rdata;
        logic        err;
        do begin
            apbRead(hubLinearPkg::STATUS, rdata, err);
        end while (!rdata[1]);
    endtask

    task automatic queueResults(
        input  bit                                 relu,
        output logic [`HUB_ODIM-1:0][`HUB_WID-1:0] got
    );
        logic [31:0] rdata;
        logic        err;
        resCheck     entry;
        for (int o = 0; o < `HUB_ODIM; o++) begin
            apbRead(wordAddr(hubLinearPkg::RES0, o), rdata, err);
            got[o]       = rdata[`HUB_WID-1:0];
            entry.outIdx = 8'(o);
            entry.expVal = `HUB_WID'(expectedResult(featV, weigV, o, relu));
            entry.gotVal = rdata[`HUB_WID-1:0];
            checkQ.push_back(entry);
        end
        wait (checkQ.size() == 0);
    endtask

    task automatic fullRun(input bit relu, output logic [`HUB_ODIM-1:0][`HUB_WID-1:0] got);
        loadOperands();
        startRun(relu);
        waitDone();
        queueResults(relu, got);
    endtask

    initial begin
        logic [31:0]                        rdata;
        logic                               err;
        bit                                 relu;
        logic [`HUB_ODIM-1:0][`HUB_WID-1:0] resA;
        logic [`HUB_ODIM-1:0][`HUB_WID-1:0] resB;
        logic [`HUB_WID-1:0]                vals[3];

        void'($urandom(32'h1d580c65));
        arstN = 1'b0;
        apbIn = '0;
        featV = '0;
        weigV = '0;
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;
        @(posedge clk);
        #1;

        openTest();
        randomOperands();
        loadOperands();
        for (int i = 0; i < `HUB_IDIM; i++) begin
            apbRead(wordAddr(hubLinearPkg::FEAT0, i), rdata, err);
            if (rdata[`HUB_WID-1:0] !== featV[i]) begin
                $display("MISMATCH at %0t: FEAT%0d read %0d, wrote %0d", $time, i,
                         rdata[`HUB_WID-1:0], featV[i]);
                errCount++;
            end
        end
        for (int w = 0; w < `HUB_ODIM * `HUB_IDIM; w++) begin
            apbRead(wordAddr(hubLinearPkg::WEIG0, w), rdata, err);
            if (rdata[`HUB_WID-1:0] !== weigV[w]) begin
                $display("MISMATCH at %0t: WEIG%0d read %0d, wrote %0d", $time, w,
                         rdata[`HUB_WID-1:0], weigV[w]);
                errCount++;
            end
        end
        apbRead(8'h08, rdata, err);
        if (err !== 1'b1) begin
            $display("error at %0t: unmapped address 0x08 gave no pslverr", $time);
            errCount++;
        end
        closeTest("register access");

        openTest();
        vals[0] = 0;
        vals[1] = 63;
        vals[2] = 32;
        for (int v = 0; v < 3; v++) begin
            featV = {`HUB_IDIM{vals[v]}};
            weigV = {(`HUB_ODIM * `HUB_IDIM){vals[v]}};
            fullRun(1'b1, resA);
        end
        closeTest("directed relu runs");

        openTest();
        for (int r = 0; r < 12; r++) begin
            randomOperands();
            relu = 1'($urandom_range(0, 1));
            fullRun(relu, resA);
        end
        closeTest("random runs");

        // anti-correlated streams land below the bipolar zero
        openTest();
        featV = {`HUB_IDIM{6'd48}};
        weigV = {(`HUB_ODIM * `HUB_IDIM){6'd16}};
        fullRun(1'b0, resA);
        startRun(1'b1);
        waitDone();
        queueResults(1'b1, resB);
        if (resA == resB) begin
            $display("error at %0t: results with relu off equal those with relu on", $time);
            errCount++;
        end
        closeTest("relu off");

        openTest();
        randomOperands();
        relu = 1'($urandom_range(0, 1));
        loadOperands();
        startRun(relu);
        apbWrite(hubLinearPkg::FEAT0, 32'(~featV[0]), err);
        if (err !== 1'b1) begin
            $display("error at %0t: feature write during a run gave no pslverr", $time);
            errCount++;
        end
        waitDone();
        queueResults(relu, resA);
        apbRead(hubLinearPkg::FEAT0, rdata, err);
        if (rdata[`HUB_WID-1:0] !== featV[0]) begin
            $display("MISMATCH at %0t: FEAT0 read %0d after refused write, expected %0d",
                     $time, rdata[`HUB_WID-1:0], featV[0]);
            errCount++;
        end
        closeTest("busy protection");

        // operands still loaded from the previous test
        openTest();
        startRun(1'b1);
        apbRead(hubLinearPkg::STATUS, rdata, err);
        if (rdata[1:0] !== 2'b01) begin
            $display("error at %0t: status after start was not busy", $time);
            errCount++;
        end
        waitDone();
        apbRead(hubLinearPkg::STATUS, rdata, err);
        if (rdata[1:0] !== 2'b10) begin
            $display("error at %0t: status after the run was not done and idle", $time);
            errCount++;
        end
        queueResults(1'b1, resA);
        closeTest("status");

        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
